/* rtl/wb_addr_decode.sv */
`timescale 1ns/1ps
`include "wb_xbar_settings.svh"

module wb_addr_decode (
	input  logic               clk_i,
	input  logic               rstn_i,
	input  logic               cyc_i,
	input  logic               stb_i,
	input  wb_xbar_pkg::addr_t adr_i,
	// Routed ack or err of this master
	input  logic               done_i,
	output wb_xbar_pkg::tid_t  tgt_o
);

	// Cycle in flight, target latched
	logic busy;

	// Map an address onto a slave window
	function automatic wb_xbar_pkg::tid_t addr2tgt(input wb_xbar_pkg::addr_t adr);
		wb_xbar_pkg::tid_t t;
		// Unmapped by default
		t = wb_xbar_pkg::ERR_TGT;
		if (adr >= `WB_S0_BASE && adr <= `WB_S0_LIMIT) begin
			t = 3'd0;
		end else if (adr >= `WB_S1_BASE && adr <= `WB_S1_LIMIT) begin
			t = 3'd1;
		end else if (adr >= `WB_S2_BASE && adr <= `WB_S2_LIMIT) begin
			t = 3'd2;
		end else if (adr >= `WB_S3_BASE && adr <= `WB_S3_LIMIT) begin
			t = 3'd3;
		end
		return t;
	endfunction

	// Two states
	// Idle waits for a strobe, busy waits for the routed response
	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			busy <= 1'b0;
			tgt_o <= wb_xbar_pkg::NO_TGT;
		end else if (!busy) begin
			// New strobed cycle
			if (cyc_i && stb_i) begin
				busy <= 1'b1;
				// Address is stable until the response
				tgt_o <= addr2tgt(adr_i);
			end
		end else if (done_i) begin
			// Response seen, drop the request to the target
			busy <= 1'b0;
			tgt_o <= wb_xbar_pkg::NO_TGT;
		end
	end

	// The target arbiter releases one edge later,
	// when it samples this selection back at NO_TGT

endmodule

/* rtl/wb_decode_err.sv */
`timescale 1ns/1ps

module wb_decode_err (
	input  logic clk_i,
	input  logic rstn_i,
	// Request forwarded by the error target port
	input  logic cyc_i,
	input  logic stb_i,
	output logic err_o
);

	// Single-cycle err for every strobe, never ack
	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			err_o <= 1'b0;
		end else begin
			// Low again on the edge the master sees err,
			// by then the forwarded strobe is gone
			err_o <= cyc_i && stb_i && !err_o;
		end
	end

endmodule

/* rtl/wb_resp_route.sv */
`timescale 1ns/1ps
`include "wb_xbar_settings.svh"

module wb_resp_route (
	// Latched target of each master
	input  wb_xbar_pkg::tid_t        tgt_i [`WB_N_MASTERS],
	// Grant state of each target
	input  logic [`WB_N_SLAVES:0]    gnt_i,
	input  wb_xbar_pkg::mid_t        gnt_id_i [`WB_N_SLAVES+1],
	// Target responses
	input  logic [`WB_N_SLAVES:0]    t_ack_i,
	input  logic [`WB_N_SLAVES:0]    t_err_i,
	input  wb_xbar_pkg::data_t       t_dat_i [`WB_N_SLAVES+1],
	// Responses back to the masters
	output logic [`WB_N_MASTERS-1:0] ack_o,
	output logic [`WB_N_MASTERS-1:0] err_o,
	output wb_xbar_pkg::data_t       dat_o [`WB_N_MASTERS]
);

	localparam int N_M = `WB_N_MASTERS;
	localparam int N_TGT = `WB_N_SLAVES + 1;

	// Purely combinational, no added latency
	always_comb begin
		for (int m = 0; m < N_M; m++) begin
			ack_o[m] = 1'b0;
			err_o[m] = 1'b0;
			dat_o[m] = '0;
			// At most one target matches
			// NO_TGT matches none
			for (int t = 0; t < N_TGT; t++) begin
				if (tgt_i[m] == wb_xbar_pkg::tid_t'(t) && gnt_i[t] &&
						gnt_id_i[t] == wb_xbar_pkg::mid_t'(m)) begin
					// Target serves this master right now
					ack_o[m] = t_ack_i[t];
					err_o[m] = t_err_i[t];
					dat_o[m] = t_dat_i[t];
				end
			end
		end
	end

endmodule

/* rtl/wb_target_port.sv */
`timescale 1ns/1ps
`include "wb_xbar_settings.svh"

module wb_target_port (
	input  logic                     clk_i,
	input  logic                     rstn_i,
	// Masters currently addressing this target
	input  wb_xbar_pkg::req_vec_t    req_i,
	input  logic [`WB_N_MASTERS-1:0] cyc_i,
	input  logic [`WB_N_MASTERS-1:0] stb_i,
	input  logic [`WB_N_MASTERS-1:0] we_i,
	input  wb_xbar_pkg::addr_t       adr_i [`WB_N_MASTERS],
	input  wb_xbar_pkg::sel_t        sel_i [`WB_N_MASTERS],
	input  wb_xbar_pkg::data_t       dat_i [`WB_N_MASTERS],
	// Grant state
	output logic                     gnt_o,
	output wb_xbar_pkg::mid_t        gnt_id_o,
	// Request forwarded to the target
	output logic                     cyc_o,
	output logic                     stb_o,
	output logic                     we_o,
	output wb_xbar_pkg::addr_t       adr_o,
	output wb_xbar_pkg::sel_t        sel_o,
	output wb_xbar_pkg::data_t       dat_o
);

	localparam int N_M = `WB_N_MASTERS;

	// One-hot of the most recent grant
	wb_xbar_pkg::req_vec_t last_gnt;
	// Masters above the last grant
	wb_xbar_pkg::req_vec_t above;
	// Requests that win over the rest
	wb_xbar_pkg::req_vec_t masked_req;
	wb_xbar_pkg::req_vec_t pick_req;
	// Master the arbiter would grant now
	wb_xbar_pkg::mid_t pick_id;
	// Granted master still requesting
	logic fwd;

	// Bit i set when the last grant sits below i
	always_comb begin
		above = '0;
		for (int i = 1; i < N_M; i++) begin
			above[i] = above[i-1] | last_gnt[i-1];
		end
	end

	assign masked_req = req_i & above;

	// First requester above the last grant,
	// wrap to the lowest when none is above
	assign pick_req = (|masked_req) ? masked_req : req_i;

	// Lowest set bit of the chosen set
	always_comb begin
		pick_id = '0;
		for (int i = N_M - 1; i >= 0; i--) begin
			if (pick_req[i]) begin
				pick_id = wb_xbar_pkg::mid_t'(i);
			end
		end
	end

	// Free port grants on the first edge with any request
	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			gnt_o <= 1'b0;
			gnt_id_o <= '0;
			last_gnt <= '0;
		end else if (!gnt_o) begin
			if (|req_i) begin
				gnt_o <= 1'b1;
				gnt_id_o <= pick_id;
				// Remember the winner for the next round
				last_gnt <= wb_xbar_pkg::req_vec_t'(1) << pick_id;
			end
		end else if (!req_i[gnt_id_o]) begin
			// Granted master has finished its cycle
			gnt_o <= 1'b0;
		end
	end

	// Forward only while the granted master still holds its bit
	// A fresh cycle of the same master waits for a new grant
	assign fwd = gnt_o && req_i[gnt_id_o];

	// Request mux, zeros when idle
	always_comb begin
		cyc_o = 1'b0;
		stb_o = 1'b0;
		we_o = 1'b0;
		adr_o = '0;
		sel_o = '0;
		dat_o = '0;
		if (fwd) begin
			cyc_o = cyc_i[gnt_id_o];
			stb_o = stb_i[gnt_id_o];
			we_o = we_i[gnt_id_o];
			adr_o = adr_i[gnt_id_o];
			sel_o = sel_i[gnt_id_o];
			dat_o = dat_i[gnt_id_o];
		end
	end

endmodule

/* rtl/wb_xbar_3x4.sv */
`timescale 1ns/1ps
`include "wb_xbar_settings.svh"

module wb_xbar_3x4 (
	input  logic               clk,
	input  logic               rstn,
	// Master 0
	input  logic               m0_cyc_i,
	input  logic               m0_stb_i,
	input  logic               m0_we_i,
	input  wb_xbar_pkg::addr_t m0_adr_i,
	input  wb_xbar_pkg::sel_t  m0_sel_i,
	input  wb_xbar_pkg::data_t m0_dat_w_i,
	output logic               m0_ack_o,
	output logic               m0_err_o,
	output wb_xbar_pkg::data_t m0_dat_r_o,
	// Master 1
	input  logic               m1_cyc_i,
	input  logic               m1_stb_i,
	input  logic               m1_we_i,
	input  wb_xbar_pkg::addr_t m1_adr_i,
	input  wb_xbar_pkg::sel_t  m1_sel_i,
	input  wb_xbar_pkg::data_t m1_dat_w_i,
	output logic               m1_ack_o,
	output logic               m1_err_o,
	output wb_xbar_pkg::data_t m1_dat_r_o,
	// Master 2
	input  logic               m2_cyc_i,
	input  logic               m2_stb_i,
	input  logic               m2_we_i,
	input  wb_xbar_pkg::addr_t m2_adr_i,
	input  wb_xbar_pkg::sel_t  m2_sel_i,
	input  wb_xbar_pkg::data_t m2_dat_w_i,
	output logic               m2_ack_o,
	output logic               m2_err_o,
	output wb_xbar_pkg::data_t m2_dat_r_o,
	// Slave 0
	output logic               s0_cyc_o,
	output logic               s0_stb_o,
	output logic               s0_we_o,
	output wb_xbar_pkg::addr_t s0_adr_o,
	output wb_xbar_pkg::sel_t  s0_sel_o,
	output wb_xbar_pkg::data_t s0_dat_w_o,
	input  logic               s0_ack_i,
	input  logic               s0_err_i,
	input  wb_xbar_pkg::data_t s0_dat_r_i,
	// Slave 1
	output logic               s1_cyc_o,
	output logic               s1_stb_o,
	output logic               s1_we_o,
	output wb_xbar_pkg::addr_t s1_adr_o,
	output wb_xbar_pkg::sel_t  s1_sel_o,
	output wb_xbar_pkg::data_t s1_dat_w_o,
	input  logic               s1_ack_i,
	input  logic               s1_err_i,
	input  wb_xbar_pkg::data_t s1_dat_r_i,
	// Slave 2
	output logic               s2_cyc_o,
	output logic               s2_stb_o,
	output logic               s2_we_o,
	output wb_xbar_pkg::addr_t s2_adr_o,
	output wb_xbar_pkg::sel_t  s2_sel_o,
	output wb_xbar_pkg::data_t s2_dat_w_o,
	input  logic               s2_ack_i,
	input  logic               s2_err_i,
	input  wb_xbar_pkg::data_t s2_dat_r_i,
	// Slave 3
	output logic               s3_cyc_o,
	output logic               s3_stb_o,
	output logic               s3_we_o,
	output wb_xbar_pkg::addr_t s3_adr_o,
	output wb_xbar_pkg::sel_t  s3_sel_o,
	output wb_xbar_pkg::data_t s3_dat_w_o,
	input  logic               s3_ack_i,
	input  logic               s3_err_i,
	input  wb_xbar_pkg::data_t s3_dat_r_i
);

	localparam int N_M = `WB_N_MASTERS;
	localparam int N_S = `WB_N_SLAVES;
	// Slaves plus the error target
	localparam int N_TGT = `WB_N_SLAVES + 1;

	// Master side as arrays
	logic [N_M-1:0] m_cyc;
	logic [N_M-1:0] m_stb;
	logic [N_M-1:0] m_we;
	wb_xbar_pkg::addr_t m_adr [N_M];
	wb_xbar_pkg::sel_t m_sel [N_M];
	wb_xbar_pkg::data_t m_dat_w [N_M];
	logic [N_M-1:0] m_ack;
	logic [N_M-1:0] m_err;
	wb_xbar_pkg::data_t m_dat_r [N_M];

	// Selection of each master, request vector and grant of each target
	wb_xbar_pkg::tid_t tgt [N_M];
	wb_xbar_pkg::req_vec_t t_req [N_TGT];
	logic [N_TGT-1:0] gnt;
	wb_xbar_pkg::mid_t gnt_id [N_TGT];

	// Target side, the error target only uses cyc and stb
	logic [N_TGT-1:0] t_cyc;
	logic [N_TGT-1:0] t_stb;
	logic [N_S-1:0] t_we;
	wb_xbar_pkg::addr_t t_adr [N_S];
	wb_xbar_pkg::sel_t t_sel [N_S];
	wb_xbar_pkg::data_t t_dat_w [N_S];
	logic [N_TGT-1:0] t_ack;
	logic [N_TGT-1:0] t_err;
	wb_xbar_pkg::data_t t_dat_r [N_TGT];
	// Error target response
	logic dec_err;

	// Gather master requests
	assign m_cyc = {m2_cyc_i, m1_cyc_i, m0_cyc_i};
	assign m_stb = {m2_stb_i, m1_stb_i, m0_stb_i};
	assign m_we = {m2_we_i, m1_we_i, m0_we_i};
	assign m_adr = '{m0_adr_i, m1_adr_i, m2_adr_i};
	assign m_sel = '{m0_sel_i, m1_sel_i, m2_sel_i};
	assign m_dat_w = '{m0_dat_w_i, m1_dat_w_i, m2_dat_w_i};

	// Master responses
	assign {m2_ack_o, m1_ack_o, m0_ack_o} = m_ack;
	assign {m2_err_o, m1_err_o, m0_err_o} = m_err;
	assign m0_dat_r_o = m_dat_r[0];
	assign m1_dat_r_o = m_dat_r[1];
	assign m2_dat_r_o = m_dat_r[2];

	// Slave requests
	assign {s3_cyc_o, s2_cyc_o, s1_cyc_o, s0_cyc_o} = t_cyc[N_S-1:0];
	assign {s3_stb_o, s2_stb_o, s1_stb_o, s0_stb_o} = t_stb[N_S-1:0];
	assign {s3_we_o, s2_we_o, s1_we_o, s0_we_o} = t_we;
	assign s0_adr_o = t_adr[0];
	assign s1_adr_o = t_adr[1];
	assign s2_adr_o = t_adr[2];
	assign s3_adr_o = t_adr[3];
	assign s0_sel_o = t_sel[0];
	assign s1_sel_o = t_sel[1];
	assign s2_sel_o = t_sel[2];
	assign s3_sel_o = t_sel[3];
	assign s0_dat_w_o = t_dat_w[0];
	assign s1_dat_w_o = t_dat_w[1];
	assign s2_dat_w_o = t_dat_w[2];
	assign s3_dat_w_o = t_dat_w[3];

	// Target responses, error target never acks and reads zero
	assign t_ack = {1'b0, s3_ack_i, s2_ack_i, s1_ack_i, s0_ack_i};
	assign t_err = {dec_err, s3_err_i, s2_err_i, s1_err_i, s0_err_i};
	assign t_dat_r = '{s0_dat_r_i, s1_dat_r_i, s2_dat_r_i, s3_dat_r_i,
		wb_xbar_pkg::data_t'(0)};

	// One decoder per master
	for (genvar m = 0; m < N_M; m++) begin : g_dec
		wb_addr_decode u_dec (
			.clk_i  (clk),
			.rstn_i (rstn),
			.cyc_i  (m_cyc[m]),
			.stb_i  (m_stb[m]),
			.adr_i  (m_adr[m]),
			.done_i (m_ack[m] | m_err[m]),
			.tgt_o  (tgt[m])
		);
	end

	// Master m requests target t while its selection is t
	for (genvar t = 0; t < N_TGT; t++) begin : g_req
		for (genvar m = 0; m < N_M; m++) begin : g_bit
			assign t_req[t][m] = (tgt[m] == wb_xbar_pkg::tid_t'(t));
		end
	end

	// Arbiter and forwarder per slave
	for (genvar s = 0; s < N_S; s++) begin : g_port
		wb_target_port u_port (
			.clk_i    (clk),
			.rstn_i   (rstn),
			.req_i    (t_req[s]),
			.cyc_i    (m_cyc),
			.stb_i    (m_stb),
			.we_i     (m_we),
			.adr_i    (m_adr),
			.sel_i    (m_sel),
			.dat_i    (m_dat_w),
			.gnt_o    (gnt[s]),
			.gnt_id_o (gnt_id[s]),
			.cyc_o    (t_cyc[s]),
			.stb_o    (t_stb[s]),
			.we_o     (t_we[s]),
			.adr_o    (t_adr[s]),
			.sel_o    (t_sel[s]),
			.dat_o    (t_dat_w[s])
		);
	end

	// Error target port, only the strobe matters there
	wb_target_port u_err_port (
		.clk_i    (clk),
		.rstn_i   (rstn),
		.req_i    (t_req[N_S]),
		.cyc_i    (m_cyc),
		.stb_i    (m_stb),
		.we_i     (m_we),
		.adr_i    (m_adr),
		.sel_i    (m_sel),
		.dat_i    (m_dat_w),
		.gnt_o    (gnt[N_S]),
		.gnt_id_o (gnt_id[N_S]),
		.cyc_o    (t_cyc[N_S]),
		.stb_o    (t_stb[N_S]),
		.we_o     (),
		.adr_o    (),
		.sel_o    (),
		.dat_o    ()
	);

	wb_decode_err u_dec_err (
		.clk_i  (clk),
		.rstn_i (rstn),
		.cyc_i  (t_cyc[N_S]),
		.stb_i  (t_stb[N_S]),
		.err_o  (dec_err)
	);

	// Route responses back to the masters
	wb_resp_route u_route (
		.tgt_i    (tgt),
		.gnt_i    (gnt),
		.gnt_id_i (gnt_id),
		.t_ack_i  (t_ack),
		.t_err_i  (t_err),
		.t_dat_i  (t_dat_r),
		.ack_o    (m_ack),
		.err_o    (m_err),
		.dat_o    (m_dat_r)
	);

endmodule

/* rtl/wb_xbar_pkg.sv */
`include "wb_xbar_settings.svh"

package wb_xbar_pkg;

	// Wishbone address
	typedef logic [`WB_ADDR_W-1:0] addr_t;

	// Data word, read or write
	typedef logic [`WB_DATA_W-1:0] data_t;

	// Byte selects
	typedef logic [`WB_SEL_W-1:0] sel_t;

	// Master index, 0 to 2
	typedef logic [1:0] mid_t;

	// Target index
	// 0 to 3 are the slaves, 4 the error target, 7 nothing selected
	typedef logic [2:0] tid_t;

	// One request bit per master
	typedef logic [`WB_N_MASTERS-1:0] req_vec_t;

	// Internal decode-error target
	localparam tid_t ERR_TGT = 3'd4;
	// No cycle in flight
	localparam tid_t NO_TGT = 3'd7;

endpackage

/* rtl/wb_xbar_settings.svh */
`ifndef WB_XBAR_SETTINGS_SVH
`define WB_XBAR_SETTINGS_SVH

// Bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32
// One select bit per data byte
`define WB_SEL_W (`WB_DATA_W / 8)

// Crossbar size
`define WB_N_MASTERS 3
`define WB_N_SLAVES 4

// Slave windows, limits inclusive
`define WB_S0_BASE 32'h0000_0000
`define WB_S0_LIMIT 32'h0000_0FFF
`define WB_S1_BASE 32'h0000_1000
`define WB_S1_LIMIT 32'h0000_1FFF
`define WB_S2_BASE 32'h0000_2000
`define WB_S2_LIMIT 32'h0000_2FFF
`define WB_S3_BASE 32'h0000_3000
`define WB_S3_LIMIT 32'h0000_3FFF
// Anything outside these four goes to the decode-error target

`endif

/* tests/tb_wb_xbar.sv */
`timescale 1ns/1ps
`include "wb_xbar_settings.svh"

module tb_wb_xbar;

	localparam int N_M = `WB_N_MASTERS;
	localparam int N_S = `WB_N_SLAVES;
	// About four times the longest expected run
	localparam int MAX_CYCLES = 4000;
	// Cycles per master in the shared-slave test
	localparam int RR_N = 6;

	logic clk;
	logic rstn;
	integer seed;
	int errors;
	int tests_run;
	int tests_passed;
	int cycles;

	// Master side
	logic [N_M-1:0] m_cyc;
	logic [N_M-1:0] m_stb;
	logic [N_M-1:0] m_we;
	wb_xbar_pkg::addr_t m_adr [N_M];
	wb_xbar_pkg::sel_t m_sel [N_M];
	wb_xbar_pkg::data_t m_dat_w [N_M];
	logic [N_M-1:0] m_ack;
	logic [N_M-1:0] m_err;
	wb_xbar_pkg::data_t m_dat_r [N_M];
	// Cycle in flight goes to an unmapped address
	logic [N_M-1:0] exp_err;

	// Slave side
	logic [N_S-1:0] s_cyc;
	logic [N_S-1:0] s_stb;
	logic [N_S-1:0] s_we;
	wb_xbar_pkg::addr_t s_adr [N_S];
	wb_xbar_pkg::sel_t s_sel [N_S];
	wb_xbar_pkg::data_t s_dat_w [N_S];
	logic [N_S-1:0] s_ack;
	logic [N_S-1:0] s_err;
	wb_xbar_pkg::data_t s_dat_r [N_S];
	logic [1:0] s_dly [N_S];

	// Checker state
	logic strobed;
	logic [N_M-1:0] pend [N_S];
	// Masters served on slave s since master k began waiting there
	logic [N_M-1:0] served [N_S][N_M];
	logic [N_S-1:0] rr_repeat;
	logic [N_S-1:0] misroute;

	wb_xbar_3x4 uut (
		.clk        (clk),
		.rstn       (rstn),
		.m0_cyc_i   (m_cyc[0]),
		.m0_stb_i   (m_stb[0]),
		.m0_we_i    (m_we[0]),
		.m0_adr_i   (m_adr[0]),
		.m0_sel_i   (m_sel[0]),
		.m0_dat_w_i (m_dat_w[0]),
		.m0_ack_o   (m_ack[0]),
		.m0_err_o   (m_err[0]),
		.m0_dat_r_o (m_dat_r[0]),
		.m1_cyc_i   (m_cyc[1]),
		.m1_stb_i   (m_stb[1]),
		.m1_we_i    (m_we[1]),
		.m1_adr_i   (m_adr[1]),
		.m1_sel_i   (m_sel[1]),
		.m1_dat_w_i (m_dat_w[1]),
		.m1_ack_o   (m_ack[1]),
		.m1_err_o   (m_err[1]),
		.m1_dat_r_o (m_dat_r[1]),
		.m2_cyc_i   (m_cyc[2]),
		.m2_stb_i   (m_stb[2]),
		.m2_we_i    (m_we[2]),
		.m2_adr_i   (m_adr[2]),
		.m2_sel_i   (m_sel[2]),
		.m2_dat_w_i (m_dat_w[2]),
		.m2_ack_o   (m_ack[2]),
		.m2_err_o   (m_err[2]),
		.m2_dat_r_o (m_dat_r[2]),
		.s0_cyc_o   (s_cyc[0]),
		.s0_stb_o   (s_stb[0]),
		.s0_we_o    (s_we[0]),
		.s0_adr_o   (s_adr[0]),
		.s0_sel_o   (s_sel[0]),
		.s0_dat_w_o (s_dat_w[0]),
		.s0_ack_i   (s_ack[0]),
		.s0_err_i   (s_err[0]),
		.s0_dat_r_i (s_dat_r[0]),
		.s1_cyc_o   (s_cyc[1]),
		.s1_stb_o   (s_stb[1]),
		.s1_we_o    (s_we[1]),
		.s1_adr_o   (s_adr[1]),
		.s1_sel_o   (s_sel[1]),
		.s1_dat_w_o (s_dat_w[1]),
		.s1_ack_i   (s_ack[1]),
		.s1_err_i   (s_err[1]),
		.s1_dat_r_i (s_dat_r[1]),
		.s2_cyc_o   (s_cyc[2]),
		.s2_stb_o   (s_stb[2]),
		.s2_we_o    (s_we[2]),
		.s2_adr_o   (s_adr[2]),
		.s2_sel_o   (s_sel[2]),
		.s2_dat_w_o (s_dat_w[2]),
		.s2_ack_i   (s_ack[2]),
		.s2_err_i   (s_err[2]),
		.s2_dat_r_i (s_dat_r[2]),
		.s3_cyc_o   (s_cyc[3]),
		.s3_stb_o   (s_stb[3]),
		.s3_we_o    (s_we[3]),
		.s3_adr_o   (s_adr[3]),
		.s3_sel_o   (s_sel[3]),
		.s3_dat_w_o (s_dat_w[3]),
		.s3_ack_i   (s_ack[3]),
		.s3_err_i   (s_err[3]),
		.s3_dat_r_i (s_dat_r[3])
	);

	// One memory per slave, so a misrouted access reads back wrong data
	for (genvar s = 0; s < N_S; s++) begin : g_slv
		wb_slave_model #(.IDX(s)) u_slv (
			.clk_i  (clk),
			.rstn_i (rstn),
			.cyc_i  (s_cyc[s]),
			.stb_i  (s_stb[s]),
			.we_i   (s_we[s]),
			.adr_i  (s_adr[s]),
			.sel_i  (s_sel[s]),
			.dat_i  (s_dat_w[s]),
			.dly_i  (s_dly[s]),
			.ack_o  (s_ack[s]),
			.err_o  (s_err[s]),
			.dat_o  (s_dat_r[s])
		);
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Memory map: four 4K windows from 0, everything else is unmapped (4)
	function automatic int window_of(input wb_xbar_pkg::addr_t a);
		if (a < 32'h0000_4000) begin
			return int'(a[13:12]);
		end
		return 4;
	endfunction

	// Fresh ack delay of 0 to 3 for every slave on every edge
	always @(posedge clk) begin
		int r;
		for (int s = 0; s < N_S; s++) begin
			r = $random(seed);
			s_dly[s] <= r[1:0];
		end
	end

	always @(posedge clk) begin
		if (|m_stb) begin
			strobed <= 1'b1;
		end
	end

	// Masters with a cycle open towards each slave
	always_comb begin
		for (int s = 0; s < N_S; s++) begin
			for (int k = 0; k < N_M; k++) begin
				pend[s][k] = m_cyc[k] && window_of(m_adr[k]) == s;
			end
		end
	end

	// Collect who gets served while a master waits on the same slave
	always @(posedge clk) begin
		if (!rstn) begin
			for (int s = 0; s < N_S; s++) begin
				for (int k = 0; k < N_M; k++) begin
					served[s][k] <= '0;
				end
			end
		end else begin
			for (int s = 0; s < N_S; s++) begin
				for (int k = 0; k < N_M; k++) begin
					// Own turn or end of waiting starts over
					if (!pend[s][k] ||
							(s_ack[s] && s_stb[s] && s_adr[s][9:8] == k)) begin
						served[s][k] <= '0;
					end else if (s_ack[s] && s_stb[s]) begin
						served[s][k][s_adr[s][9:8]] <= 1'b1;
					end
				end
			end
		end
	end

	// Some master served a second time while another kept waiting
	always_comb begin
		for (int s = 0; s < N_S; s++) begin
			rr_repeat[s] = 1'b0;
			for (int k = 0; k < N_M; k++) begin
				if (pend[s][k] && s_ack[s] && s_stb[s] && s_adr[s][9:8] != k &&
						served[s][k][s_adr[s][9:8]]) begin
					rr_repeat[s] = 1'b1;
				end
			end
		end
	end

	// Slave strobe must carry the whole request of a master that addresses it
	always_comb begin
		logic hit;
		for (int s = 0; s < N_S; s++) begin
			misroute[s] = 1'b0;
			if (s_stb[s]) begin
				hit = 1'b0;
				for (int k = 0; k < N_M; k++) begin
					if (m_cyc[k] && m_stb[k] && m_adr[k] == s_adr[s] &&
							m_we[k] == s_we[s] && m_sel[k] == s_sel[s] &&
							m_dat_w[k] == s_dat_w[s]) begin
						hit = 1'b1;
					end
				end
				misroute[s] = !hit || window_of(s_adr[s]) != s;
			end
		end
	end

	a_idle: assert property (@(posedge clk) disable iff (!rstn)
		strobed || (s_cyc == '0 && s_stb == '0 && m_ack == '0 && m_err == '0))
		else begin
			$display("CHECK FAILED at %0t: bus active before any master strobed", $time);
			errors++;
		end

	a_stb_cyc: assert property (@(posedge clk) disable iff (!rstn) (s_stb & ~s_cyc) == '0)
		else begin
			$display("CHECK FAILED at %0t: slave stb high without cyc", $time);
			errors++;
		end

	a_ack_err: assert property (@(posedge clk) disable iff (!rstn) (m_ack & m_err) == '0)
		else begin
			$display("CHECK FAILED at %0t: master ack and err high together", $time);
			errors++;
		end

	a_no_ack_unmapped: assert property (@(posedge clk) disable iff (!rstn)
		(m_ack & exp_err) == '0)
		else begin
			$display("CHECK FAILED at %0t: ack for an unmapped address", $time);
			errors++;
		end

	a_no_err_mapped: assert property (@(posedge clk) disable iff (!rstn)
		(m_err & ~exp_err) == '0)
		else begin
			$display("CHECK FAILED at %0t: err for a mapped address", $time);
			errors++;
		end

	a_quiet_slaves: assert property (@(posedge clk) disable iff (!rstn)
		!(|(m_cyc & exp_err) && (m_cyc & ~exp_err) == '0 && s_stb != '0))
		else begin
			$display("CHECK FAILED at %0t: slave strobed during an unmapped access", $time);
			errors++;
		end

	a_route: assert property (@(posedge clk) disable iff (!rstn) misroute == '0)
		else begin
			$display("CHECK FAILED at %0t: slave request from a master not addressing it",
				$time);
			errors++;
		end

	a_round_robin: assert property (@(posedge clk) disable iff (!rstn) rr_repeat == '0)
		else begin
			$display("CHECK FAILED at %0t: master served twice while another waited", $time);
			errors++;
		end

	// One classic cycle, returns on the edge that samples ack or err
	task automatic wb_access(input int m, input logic we, input wb_xbar_pkg::addr_t adr,
			input wb_xbar_pkg::data_t wdat, output wb_xbar_pkg::data_t rdat,
			output logic got_err);
		@(posedge clk);
		m_cyc[m] <= 1'b1;
		m_stb[m] <= 1'b1;
		m_we[m] <= we;
		m_adr[m] <= adr;
		m_sel[m] <= '1;
		m_dat_w[m] <= wdat;
		exp_err[m] <= (window_of(adr) == 4);
		do begin
			@(posedge clk);
		end while (!(m_ack[m] || m_err[m]));
		rdat = m_dat_r[m];
		got_err = m_err[m];
		// Idle for at least one cycle before the next strobe
		m_cyc[m] <= 1'b0;
		m_stb[m] <= 1'b0;
		m_we[m] <= 1'b0;
	endtask

	// Random write, then read back and compare
	task automatic write_read(input int m, input wb_xbar_pkg::addr_t adr);
		wb_xbar_pkg::data_t wdat;
		wb_xbar_pkg::data_t rdat;
		logic got_err;
		wdat = $random(seed);
		wb_access(m, 1'b1, adr, wdat, rdat, got_err);
		wb_access(m, 1'b0, adr, '0, rdat, got_err);
		if (rdat !== wdat) begin
			$display("CHECK FAILED at %0t: master %0d read %h at %h, expected %h",
				$time, m, rdat, adr, wdat);
			errors++;
		end
	endtask

	// Master id sits in address bits 9:8
	task automatic burst_to_slave(input int m, input int s, input int n);
		for (int i = 0; i < n; i++) begin
			write_read(m, wb_xbar_pkg::addr_t'(s * 32'h1000 + m * 32'h100 + i * 4));
		end
	endtask

	task automatic expect_err(input int m, input logic we);
		wb_xbar_pkg::data_t rdat;
		logic got_err;
		wb_access(m, we, 32'h0000_8000, 32'hdead_beef, rdat, got_err);
		if (!got_err) begin
			$display("CHECK FAILED at %0t: master %0d access to 0x8000 ended without err",
				$time, m);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			tests_passed++;
			$display("[%0t] test %s passed", $time, name);
		end else begin
			$display("[%0t] test %s failed with %0d errors", $time, name,
				errors - errs_before);
		end
	endtask

	// Ends a stuck run
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int errs_before;
		int log_before;
		seed = 32'he907;
		errors = 0;
		tests_run = 0;
		tests_passed = 0;
		strobed = 1'b0;
		rstn = 1'b0;
		m_cyc = '0;
		m_stb = '0;
		m_we = '0;
		exp_err = '0;
		for (int m = 0; m < N_M; m++) begin
			m_adr[m] = '0;
			m_sel[m] = '0;
			m_dat_w[m] = '0;
		end
		for (int s = 0; s < N_S; s++) begin
			s_dly[s] = 2'd0;
		end

		// Reset, then idle with no master active
		errs_before = errors;
		repeat (4) @(posedge clk);
		rstn <= 1'b1;
		repeat (6) @(posedge clk);
		report_test("reset_idle", errs_before);

		// Every master through every window
		errs_before = errors;
		for (int m = 0; m < N_M; m++) begin
			for (int w = 0; w < N_S; w++) begin
				write_read(m, wb_xbar_pkg::addr_t'(w * 32'h1000 + m * 32'h100 + 32'h10));
			end
		end
		report_test("all_windows", errs_before);

		errs_before = errors;
		expect_err(1, 1'b0);
		expect_err(2, 1'b1);
		report_test("unmapped", errs_before);

		// All masters contend for slave 1
		errs_before = errors;
		log_before = g_slv[1].u_slv.srv_log.size();
		fork
			burst_to_slave(0, 1, RR_N);
			burst_to_slave(1, 1, RR_N);
			burst_to_slave(2, 1, RR_N);
		join
		if (g_slv[1].u_slv.srv_log.size() != log_before + 2 * N_M * RR_N) begin
			$display("CHECK FAILED at %0t: slave 1 served %0d cycles, expected %0d", $time,
				g_slv[1].u_slv.srv_log.size() - log_before, 2 * N_M * RR_N);
			errors++;
		end
		report_test("shared_slave", errs_before);

		// Disjoint slaves in parallel
		errs_before = errors;
		fork
			burst_to_slave(0, 2, 2);
			burst_to_slave(1, 3, 2);
			burst_to_slave(2, 0, 2);
		join
		report_test("parallel", errs_before);

		repeat (4) @(posedge clk);
		$display("Tests run %0d, passed %0d, failed %0d, failed checks %0d", tests_run,
			tests_passed, tests_run - tests_passed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* tests/wb_slave_model.sv */
`timescale 1ns/1ps

module wb_slave_model #(
	parameter int IDX = 0
) (
	input  logic               clk_i,
	input  logic               rstn_i,
	input  logic               cyc_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  wb_xbar_pkg::addr_t adr_i,
	input  wb_xbar_pkg::sel_t  sel_i,
	input  wb_xbar_pkg::data_t dat_i,
	// Wait states for a strobe that starts now
	input  logic [1:0]         dly_i,
	output logic               ack_o,
	output logic               err_o,
	output wb_xbar_pkg::data_t dat_o
);

	// 1K words, indexed by the word address inside the 4K window
	wb_xbar_pkg::data_t mem [1024];
	// Strobe seen, wait states still running
	logic busy;
	logic [1:0] wait_cnt;
	logic [9:0] idx;
	// Served masters in order, id taken from address bits 9:8
	logic [1:0] srv_log [$];

	assign idx = adr_i[11:2];
	// This slave never signals an error
	assign err_o = 1'b0;

	// Fill differs per slave and per word
	initial begin
		for (int i = 0; i < 1024; i++) begin
			mem[i] = (32'(IDX) << 28) | (32'(i) << 12) | 32'(i * 3);
		end
	end

	always @(posedge clk_i) begin
		if (!rstn_i) begin
			ack_o <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= '0;
			dat_o <= '0;
		end else begin
			// Ack is a single-cycle pulse
			ack_o <= 1'b0;
			if (cyc_i && stb_i && !ack_o) begin
				if ((!busy && dly_i == 2'd0) || (busy && wait_cnt == 2'd0)) begin
					ack_o <= 1'b1;
					busy <= 1'b0;
					dat_o <= mem[idx];
					srv_log.push_back(adr_i[9:8]);
					if (we_i) begin
						for (int b = 0; b < 4; b++) begin
							if (sel_i[b]) begin
								mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
							end
						end
					end
				end else if (!busy) begin
					// First look at this strobe
					busy <= 1'b1;
					wait_cnt <= dly_i - 2'd1;
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
		end
	end

endmodule

/* wb_xbar.f */
+incdir+rtl
rtl/wb_xbar_pkg.sv
rtl/wb_addr_decode.sv
rtl/wb_target_port.sv
rtl/wb_resp_route.sv
rtl/wb_decode_err.sv
rtl/wb_xbar_3x4.sv
tests/wb_slave_model.sv
tests/tb_wb_xbar.sv
